/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_traffic
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
RUN_ARGS  := +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "Test passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/traffic_pkg.sv */
// Widths here fix the struct layouts; module ADDR_W and DATA_W must match these defaults
package traffic_pkg;

    // ----------------------------------------
    // Widths and basic types
    // ----------------------------------------
    localparam int ADDR_W = 10;
    localparam int DATA_W = 32;

    // One memory word address
    typedef logic [ADDR_W-1:0] mem_addr_t;
    // One memory word
    typedef logic [DATA_W-1:0] mem_data_t;
    // Counters and the interval period
    typedef logic [31:0] count_t;

    // ----------------------------------------
    // Register map, byte offsets
    // ----------------------------------------
    localparam logic [7:0] REG_CTRL     = 8'h00;
    localparam logic [7:0] REG_INTERVAL = 8'h04;
    localparam logic [7:0] REG_STEP     = 8'h08;
    localparam logic [7:0] REG_INJECT   = 8'h0C;
    // Read-only status
    localparam logic [7:0] REG_PASSES   = 8'h10;
    localparam logic [7:0] REG_ERRORS   = 8'h14;
    localparam logic [7:0] REG_LAST     = 8'h18;

    // Pass sequencer
    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ,
        CHECK
    } gen_state_e;

    // Generator to memory request, held until rdy
    typedef struct packed {
        logic      en;
        logic      write;
        mem_addr_t addr;
        mem_data_t wdata;
    } mem_req_s;

    // Generator results seen by the registers
    typedef struct packed {
        count_t    passes;
        count_t    errors;
        mem_data_t last_data;
    } gen_status_s;

endpackage

/* hw/block_mem.sv */
// MEM_LATENCY of at least 1; requests must hold en and fields steady until rdy
module block_mem
    import traffic_pkg::*;
#(
    parameter int ADDR_W      = 10,
    parameter int DATA_W      = 32,
    parameter int MEM_LATENCY = 3
) (
    input  logic      slow_clk,
    input  logic      rst,
    input  mem_req_s  req,
    output logic      rdy,
    output mem_data_t rdata
);

    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    logic [DATA_W-1:0] mem_q [2**ADDR_W];

    logic              busy_q;
    logic [CNT_W-1:0]  cnt_q;
    logic              write_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic              capture;

    // ----------------------------------------
    // Latency countdown
    // ----------------------------------------
    // Only an idle memory takes a new request
    assign capture = req.en && !busy_q;

    always_ff @(posedge slow_clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (capture) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(MEM_LATENCY - 1);
        end else if (busy_q) begin
            // Done after the rdy cycle
            if (cnt_q == '0)
                busy_q <= 1'b0;
            else
                cnt_q <= cnt_q - 1'b1;
        end
    end

    // One cycle pulse MEM_LATENCY cycles after capture
    assign rdy = busy_q && (cnt_q == '0);

    // Request payload
    always_ff @(posedge slow_clk) begin
        if (capture) begin
            write_q <= req.write;
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
        end
    end

    // ----------------------------------------
    // Storage accessed on the rdy cycle
    // ----------------------------------------
    always_ff @(posedge slow_clk) begin
        if (rdy && write_q)
            mem_q[addr_q] <= wdata_q;
    end

    assign rdata = mem_q[addr_q];

endmodule

/* hw/traffic_regs.sv */
// AXI4-Lite slave with single outstanding write and read; responses are always OKAY
module traffic_regs
    import traffic_pkg::*;
(
    input  logic        slow_clk,
    input  logic        rst,
    // Write address and data
    input  logic [7:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    // Write response
    output logic        bvalid,
    output logic [1:0]  bresp,
    input  logic        bready,
    // Read channels
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rvalid,
    output logic [1:0]  rresp,
    input  logic        rready,
    // Generator side
    input  gen_status_s status,
    output logic        enable,
    output count_t      interval,
    output mem_addr_t   step,
    output mem_data_t   inject_mask
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic        aw_seen_q, w_seen_q, bvalid_q, rvalid_q;
    logic [7:0]  aw_addr_q;
    logic [31:0] w_data_q, rdata_q, rd_mux;
    logic [3:0]  w_strb_q;
    logic        aw_hs, w_hs, ar_hs, aw_have, w_have;
    logic [7:0]  wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic        enable_q;
    count_t      interval_q;
    mem_addr_t   step_q;
    mem_data_t   mask_q;

    // Byte-lane merge of a write into a register
    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                          input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    // ----------------------------------------
    // Write path
    // ----------------------------------------
    // No new address or data while a response waits
    assign awready = !aw_seen_q && !bvalid_q;
    assign wready  = !w_seen_q && !bvalid_q;
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    assign aw_have = aw_seen_q || aw_hs;
    assign w_have  = w_seen_q || w_hs;
    // Latched beat if earlier, else the live one
    assign wr_addr = aw_seen_q ? aw_addr_q : awaddr;
    assign wr_data = w_seen_q ? w_data_q : wdata;
    assign wr_strb = w_seen_q ? w_strb_q : wstrb;

    always_ff @(posedge slow_clk) begin
        if (aw_hs)
            aw_addr_q <= awaddr;
        if (w_hs) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
    end

    always_ff @(posedge slow_clk) begin
        if (rst) begin
            aw_seen_q  <= 1'b0;
            w_seen_q   <= 1'b0;
            bvalid_q   <= 1'b0;
            enable_q   <= 1'b0;
            interval_q <= count_t'(16);
            step_q     <= mem_addr_t'(1);
            mask_q     <= '0;
        end else begin
            if (bvalid_q && bready)
                bvalid_q <= 1'b0;
            if (aw_have && w_have) begin
                // Both halves in, commit and respond next cycle
                aw_seen_q <= 1'b0;
                w_seen_q  <= 1'b0;
                bvalid_q  <= 1'b1;
                case (wr_addr)
                    REG_CTRL: begin
                        if (wr_strb[0])
                            enable_q <= wr_data[0];
                    end
                    REG_INTERVAL: interval_q <= merge(interval_q, wr_data, wr_strb);
                    REG_STEP:     step_q <= mem_addr_t'(merge(32'(step_q), wr_data, wr_strb));
                    REG_INJECT:   mask_q <= mem_data_t'(merge(32'(mask_q), wr_data, wr_strb));
                    default: ;
                endcase
            end else begin
                if (aw_hs)
                    aw_seen_q <= 1'b1;
                if (w_hs)
                    w_seen_q <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Read path
    // ----------------------------------------
    always_comb begin
        case (araddr)
            REG_CTRL:     rd_mux = {31'd0, enable_q};
            REG_INTERVAL: rd_mux = interval_q;
            REG_STEP:     rd_mux = 32'(step_q);
            REG_INJECT:   rd_mux = 32'(mask_q);
            REG_PASSES:   rd_mux = status.passes;
            REG_ERRORS:   rd_mux = status.errors;
            REG_LAST:     rd_mux = 32'(status.last_data);
            // Unmapped reads as zero
            default:      rd_mux = '0;
        endcase
    end

    assign arready = !rvalid_q;
    assign ar_hs   = arvalid && arready;

    always_ff @(posedge slow_clk) begin
        if (rst)
            rvalid_q <= 1'b0;
        else if (ar_hs)
            rvalid_q <= 1'b1;
        else if (rvalid_q && rready)
            rvalid_q <= 1'b0;
    end

    // Status sampled at the address beat
    always_ff @(posedge slow_clk) begin
        if (ar_hs)
            rdata_q <= rd_mux;
    end

    assign bvalid      = bvalid_q;
    assign bresp       = RESP_OKAY;
    assign rvalid      = rvalid_q;
    assign rdata       = rdata_q;
    assign rresp       = RESP_OKAY;
    assign enable      = enable_q;
    assign interval    = interval_q;
    assign step        = step_q;
    assign inject_mask = mask_q;

endmodule

/* hw/traffic_top.sv */
// Single clock domain; ADDR_W and DATA_W must equal the package widths
module traffic_top
    import traffic_pkg::*;
#(
    parameter int ADDR_W      = 10,
    parameter int DATA_W      = 32,
    parameter int MEM_LATENCY = 3
) (
    input  logic        slow_clk,
    input  logic        rst,
    // AXI4-Lite slave
    input  logic [7:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    output logic [1:0]  bresp,
    input  logic        bready,
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rvalid,
    output logic [1:0]  rresp,
    input  logic        rready
);

    // Control from registers
    logic        enable;
    count_t      interval;
    mem_addr_t   step;
    mem_data_t   inject_mask;
    gen_status_s status;
    // Memory port
    mem_req_s    mem_req;
    logic        mem_rdy;
    mem_data_t   mem_rdata;

    traffic_regs u_regs (
        .slow_clk    (slow_clk),
        .rst         (rst),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bvalid      (bvalid),
        .bresp       (bresp),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rvalid      (rvalid),
        .rresp       (rresp),
        .rready      (rready),
        .status      (status),
        .enable      (enable),
        .interval    (interval),
        .step        (step),
        .inject_mask (inject_mask)
    );

    traffic_gen #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) u_gen (
        .slow_clk    (slow_clk),
        .rst         (rst),
        .enable      (enable),
        .interval    (interval),
        .step        (step),
        .inject_mask (inject_mask),
        .rdy         (mem_rdy),
        .rdata       (mem_rdata),
        .req         (mem_req),
        .status      (status)
    );

    block_mem #(
        .ADDR_W      (ADDR_W),
        .DATA_W      (DATA_W),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_mem (
        .slow_clk (slow_clk),
        .rst      (rst),
        .req      (mem_req),
        .rdy      (mem_rdy),
        .rdata    (mem_rdata)
    );

endmodule

/* tb.f */
common/traffic_pkg.sv
hw/traffic_regs.sv
traffic_gen/traffic_gen.sv
hw/block_mem.sv
hw/traffic_top.sv
test/traffic_asserts.sv
test/tb_traffic.sv

/* test/tb_traffic.sv */
// Single slow_clk domain; MEM_LATENCY 3, interval 20, status polled over AXI4-Lite
module tb_traffic
    import traffic_pkg::*;
();

    localparam int MEM_LATENCY    = 3;
    localparam int PASS_CYCLES    = 2 * (MEM_LATENCY + 1) + 1;
    localparam int INTERVAL       = 20;
    localparam int TIMEOUT_CYCLES = 4000;

    logic        slow_clk;
    logic        rst;
    logic [7:0]  awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    int          errors = 0;
    int          cycle_count;
    int          seed = 90240;

    traffic_top #(
        .MEM_LATENCY (MEM_LATENCY)
    ) dut (
        .slow_clk (slow_clk), .rst (rst),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bvalid (bvalid), .bresp (bresp), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rvalid (rvalid), .rresp (rresp), .rready (rready)
    );

    initial begin
        slow_clk = 1'b0;
        forever #4 slow_clk = ~slow_clk;
    end

    // ----------------------------------------
    // Bus tasks entered 1 unit after an edge
    // ----------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s expected 0x%08h got 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic aw_done, w_done, aw_fire, w_fire;
        aw_done = 1'b0;
        w_done  = 1'b0;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = 4'hF;
        wvalid  = 1'b1;
        bready  = 1'b1;
        // AW and W may complete in different cycles
        while (!(aw_done && w_done)) begin
            aw_fire = awvalid && awready;
            w_fire  = wvalid && wready;
            @(posedge slow_clk);
            #1;
            if (aw_fire) begin
                aw_done = 1'b1;
                awvalid = 1'b0;
            end
            if (w_fire) begin
                w_done = 1'b1;
                wvalid = 1'b0;
            end
        end
        while (!bvalid) begin
            @(posedge slow_clk);
            #1;
        end
        check_value("BRESP", 32'd0, 32'(bresp));
        @(posedge slow_clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        logic fire;
        fire    = 1'b0;
        araddr  = addr;
        arvalid = 1'b1;
        while (!fire) begin
            fire = arready;
            @(posedge slow_clk);
            #1;
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) begin
            @(posedge slow_clk);
            #1;
        end
        data = rdata;
        check_value("RRESP", 32'd0, 32'(rresp));
        @(posedge slow_clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic check_reg(input logic [7:0] addr, input logic [31:0] expected,
                             input string name);
        logic [31:0] value;
        read_reg(addr, value);
        check_value(name, expected, value);
    endtask

    // Consistent snapshot retried if a pass landed between reads
    task automatic read_status(output logic [31:0] p, output logic [31:0] e,
                               output logic [31:0] l);
        logic [31:0] p_again;
        do begin
            read_reg(REG_PASSES, p);
            read_reg(REG_ERRORS, e);
            read_reg(REG_LAST, l);
            read_reg(REG_PASSES, p_again);
        end while (p != p_again);
    endtask

    task automatic wait_for_passes(input logic [31:0] target);
        logic [31:0] passes;
        read_reg(REG_PASSES, passes);
        while (passes < target)
            read_reg(REG_PASSES, passes);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge slow_clk);
        #1;
    endtask

    // Covers a pass already in flight when enable drops
    task automatic let_pass_finish();
        wait_cycles(PASS_CYCLES + 4);
    endtask

    // ----------------------------------------
    // Watchdog
    // ----------------------------------------
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge slow_clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] p0, e0, l0, p1, e1, l1, p2, e2, l2, value, mask;
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (3) @(posedge slow_clk);
        #1;
        rst = 1'b0;

        // Reset values and unmapped space
        check_reg(REG_CTRL, 32'd0, "CTRL");
        check_reg(REG_INTERVAL, 32'd16, "INTERVAL");
        check_reg(REG_STEP, 32'd1, "STEP");
        check_reg(REG_INJECT, 32'd0, "INJECT");
        check_reg(REG_PASSES, 32'd0, "PASSES");
        check_reg(8'h1C, 32'd0, "unmapped 0x1C");
        check_reg(8'h80, 32'd0, "unmapped 0x80");

        // Register round trip
        mask = $random(seed);
        write_reg(REG_INTERVAL, INTERVAL);
        write_reg(REG_STEP, 32'd3);
        write_reg(REG_INJECT, mask);
        check_reg(REG_INTERVAL, INTERVAL, "INTERVAL");
        check_reg(REG_STEP, 32'd3, "STEP");
        check_reg(REG_INJECT, mask, "INJECT");
        write_reg(REG_INJECT, 32'd0);

        // Healthy traffic
        write_reg(REG_CTRL, 32'd1);
        // Five intervals plus one pass latency
        wait_cycles(5 * INTERVAL + PASS_CYCLES);
        read_status(p0, e0, l0);
        if (p0 < 32'd5) begin
            errors++;
            $display("PASSES stayed below 5 with traffic enabled, read %0d", p0);
        end
        check_value("ERRORS", 32'd0, e0);
        check_value("LAST", p0 - 32'd1, l0);

        // Error injection with the mask changed only while idle
        write_reg(REG_CTRL, 32'd0);
        let_pass_finish();
        read_status(p0, e0, l0);
        mask = $random(seed);
        if (mask == 32'd0)
            mask = 32'd1;
        write_reg(REG_INJECT, mask);
        write_reg(REG_CTRL, 32'd1);
        wait_for_passes(p0 + 32'd4);
        write_reg(REG_CTRL, 32'd0);
        let_pass_finish();
        read_status(p1, e1, l1);
        check_value("ERRORS growth", p1 - p0, e1 - e0);
        check_value("LAST", (p1 - 32'd1) ^ mask, l1);

        // Wrapping step with healthy traffic
        write_reg(REG_INJECT, 32'd0);
        write_reg(REG_STEP, 32'd700);
        write_reg(REG_CTRL, 32'd1);
        wait_for_passes(p1 + 32'd5);
        write_reg(REG_CTRL, 32'd0);
        let_pass_finish();
        read_status(p2, e2, l2);
        check_value("ERRORS", e1, e2);
        check_value("LAST", p2 - 32'd1, l2);

        // Counts frozen while disabled
        read_reg(REG_PASSES, value);
        check_value("PASSES", p2, value);
        wait_cycles(3 * INTERVAL);
        read_reg(REG_PASSES, value);
        check_value("PASSES", p2, value);

        $display("Errors: %0d testbench, %0d assertion", errors, dut.u_asserts.fail_count);
        if (errors == 0 && dut.u_asserts.fail_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* test/traffic_asserts.sv */
// Checks traffic_top internals on slow_clk; assumes one pass in flight and counts failures in fail_count
module traffic_asserts
    import traffic_pkg::*;
#(
    parameter int MEM_LATENCY = 3
) (
    input logic        slow_clk,
    input logic        rst,
    input logic        enable,
    input mem_addr_t   step,
    input mem_req_s    mem_req,
    input logic        mem_rdy,
    input mem_data_t   mem_rdata,
    input gen_status_s status
);

    int   fail_count = 0;
    logic rd_done;

    // Readback beat of a pass
    assign rd_done = mem_rdy && mem_req.en && !mem_req.write;

    // ----------------------------------------
    // Memory handshake
    // ----------------------------------------
    // Request fields frozen while waiting for rdy
    hold_req: assert property (@(posedge slow_clk) disable iff (rst)
        (mem_req.en && !mem_rdy) |=> (mem_req.en && $stable(mem_req)))
        else begin
            fail_count++;
            $error("memory request dropped or changed before rdy");
        end

    // First request of a pass answered after the fixed latency
    rdy_latency: assert property (@(posedge slow_clk) disable iff (rst)
        $rose(mem_req.en) |-> ##MEM_LATENCY mem_rdy)
        else begin
            fail_count++;
            $error("rdy missing at the fixed latency after en rose");
        end

    rdy_pulse: assert property (@(posedge slow_clk) disable iff (rst)
        mem_rdy |=> !mem_rdy)
        else begin
            fail_count++;
            $error("rdy held longer than one cycle");
        end

    // No answer without a request
    rdy_orphan: assert property (@(posedge slow_clk) disable iff (rst)
        mem_rdy |-> mem_req.en)
        else begin
            fail_count++;
            $error("rdy seen with no pending request");
        end

    // ----------------------------------------
    // Generator rules
    // ----------------------------------------
    // Passes start only from an enabled tick
    start_enabled: assert property (@(posedge slow_clk) disable iff (rst)
        $rose(mem_req.en) |-> $past(enable))
        else begin
            fail_count++;
            $error("pass started while disabled");
        end

    reset_state: assert property (@(posedge slow_clk)
        rst |=> (!mem_req.en && !mem_rdy && status.passes == '0 && status.errors == '0))
        else begin
            fail_count++;
            $error("request or counters not cleared by reset");
        end

    // Expected value is the sequence, which tracks passes from zero
    errors_compare: assert property (@(posedge slow_clk) disable iff (rst)
        rd_done |-> ##2 (status.errors == $past(status.errors, 2)
            + (($past(mem_rdata, 2) != $past(status.passes, 2)) ? 32'd1 : 32'd0)))
        else begin
            fail_count++;
            $error("error count does not follow the readback compare");
        end

    // Address wraps at memory depth
    addr_step: assert property (@(posedge slow_clk) disable iff (rst)
        rd_done |-> ##2 (mem_req.addr == mem_addr_t'($past(mem_req.addr) + $past(step))))
        else begin
            fail_count++;
            $error("address did not advance by step after CHECK");
        end

endmodule

bind traffic_top traffic_asserts #(
    .MEM_LATENCY (MEM_LATENCY)
) u_asserts (
    .slow_clk  (slow_clk),
    .rst       (rst),
    .enable    (enable),
    .step      (step),
    .mem_req   (mem_req),
    .mem_rdy   (mem_rdy),
    .mem_rdata (mem_rdata),
    .status    (status)
);

/* traffic_gen/traffic_gen.sv */
// One pass in flight; ticks during a busy pass are dropped, and a pass always runs to completion
module traffic_gen
    import traffic_pkg::*;
#(
    parameter int ADDR_W = 10,
    parameter int DATA_W = 32
) (
    input  logic        slow_clk,
    input  logic        rst,
    input  logic        enable,
    input  count_t      interval,
    input  mem_addr_t   step,
    input  mem_data_t   inject_mask,
    // Memory handshake
    input  logic        rdy,
    input  mem_data_t   rdata,
    output mem_req_s    req,
    output gen_status_s status
);

    gen_state_e         state_q;
    count_t             timer_q;
    count_t             passes_q, errors_q;
    logic [ADDR_W-1:0]  addr_q;
    logic [DATA_W-1:0]  seq_q;
    logic [DATA_W-1:0]  wdata_q;
    logic [DATA_W-1:0]  rd_q;
    logic [DATA_W-1:0]  last_q;
    logic               tick;

    // ----------------------------------------
    // Interval timer
    // ----------------------------------------
    // Fires once every interval cycles
    assign tick = enable && (timer_q + 32'd1 >= interval);

    always_ff @(posedge slow_clk) begin
        if (rst || !enable)
            timer_q <= '0;
        else if (tick)
            timer_q <= '0;
        else
            timer_q <= timer_q + 32'd1;
    end

    // ----------------------------------------
    // Pass sequencer
    // ----------------------------------------
    always_ff @(posedge slow_clk) begin
        if (rst) begin
            state_q  <= IDLE;
            passes_q <= '0;
            errors_q <= '0;
            addr_q   <= '0;
            seq_q    <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (tick)
                        state_q <= WRITE;
                end
                WRITE: begin
                    if (rdy)
                        state_q <= READ;
                end
                READ: begin
                    if (rdy)
                        state_q <= CHECK;
                end
                CHECK: begin
                    state_q  <= IDLE;
                    passes_q <= passes_q + 32'd1;
                    // Readback against the unmasked value
                    if (rd_q != seq_q)
                        errors_q <= errors_q + 32'd1;
                    // Wraps at memory depth
                    addr_q   <= addr_q + step;
                    seq_q    <= seq_q + 1'b1;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Write word frozen at pass start, mask changes wait for the next pass
    always_ff @(posedge slow_clk) begin
        if (state_q == IDLE && tick)
            wdata_q <= seq_q ^ inject_mask;
        if (state_q == READ && rdy)
            rd_q <= rdata;
        if (state_q == CHECK)
            last_q <= rd_q;
    end

    // Request straight from state, stable until rdy
    always_comb begin
        req.en    = (state_q == WRITE) || (state_q == READ);
        req.write = (state_q == WRITE);
        req.addr  = addr_q;
        req.wdata = wdata_q;
    end

    // last_data is undefined until the first pass completes
    assign status.passes    = passes_q;
    assign status.errors    = errors_q;
    assign status.last_data = last_q;

endmodule
